// File: rename_core.f
source/rename_pkg.sv
source/retire_if.sv
source/free_list.sv
source/spec_rat.sv
source/reorder_buffer.sv
source/retire_rat.sv
source/rename_core.sv
testbench/rename_core_asserts.sv
testbench/rename_core_tb.sv

// File: source/free_list.sv
`timescale 1ns/1ps

module free_list #(
    parameter int NUM_PHYS_REGS = rename_pkg::NUM_PHYS_REGS
) (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     alloc_en,
    output rename_pkg::phys_idx_t    alloc_phys,
    output logic                     alloc_ok,
    input  logic                     freed_valid,
    input  rename_pkg::phys_idx_t    freed_phys,
    input  logic                     flush,
    input  logic [NUM_PHYS_REGS-1:0] mapped_mask
);

    // One bit per physical register, set means free
    logic [NUM_PHYS_REGS-1:0] free_map;
    logic [NUM_PHYS_REGS-1:0] free_next;

    // Lowest set bit wins, so scan from the top down
    always_comb begin
        alloc_phys = '0;
        for (int i = NUM_PHYS_REGS - 1; i >= 0; i--) begin
            if (free_map[i]) begin
                alloc_phys = rename_pkg::phys_idx_t'(i);
            end
        end
    end

    assign alloc_ok = |free_map;

    // Normal update: take the allocated bit, give back the freed one
    always_comb begin
        free_next = free_map;
        if (alloc_en) begin
            free_next[alloc_phys] = 1'b0;
        end
        if (freed_valid) begin
            free_next[freed_phys] = 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            // Identity mapping holds 0..NUM_ARCH_REGS
            for (int i = 0; i < NUM_PHYS_REGS; i++) begin
                free_map[i] <= (i > rename_pkg::NUM_ARCH_REGS);
            end
        end else if (flush) begin
            // Anything the retired table does not hold is free again
            free_map <= ~mapped_mask;
        end else begin
            free_map <= free_next;
        end
    end

endmodule

// File: source/rename_core.sv
`timescale 1ns/1ps

module rename_core #(
    parameter int NUM_ARCH_REGS = rename_pkg::NUM_ARCH_REGS,
    parameter int NUM_PHYS_REGS = rename_pkg::NUM_PHYS_REGS,
    parameter int ROB_DEPTH     = rename_pkg::ROB_DEPTH
) (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  dispatch_valid,
    input  rename_pkg::arch_idx_t dispatch_arch,
    output logic                  dispatch_ready,
    output rename_pkg::phys_idx_t dispatch_phys,
    output rename_pkg::rob_tag_t  dispatch_tag,
    input  logic                  complete_valid,
    input  rename_pkg::rob_tag_t  complete_tag,
    output logic                  commit_valid,
    output rename_pkg::arch_idx_t commit_arch,
    output rename_pkg::phys_idx_t commit_phys,
    output logic                  freed_valid,
    output rename_pkg::phys_idx_t freed_phys,
    input  logic                  flush
);

    logic                     accept;
    logic                     rob_full;
    logic                     alloc_ok;
    rename_pkg::phys_idx_t    alloc_phys;
    rename_pkg::phys_idx_t    old_phys;
    logic [NUM_PHYS_REGS-1:0] mapped_mask;
    rename_pkg::phys_idx_t    retired_map [NUM_ARCH_REGS:0];

    retire_if ret_bus ();

    // Dispatch handshake
    assign dispatch_ready = !rob_full && alloc_ok && !flush;
    assign accept         = dispatch_valid && dispatch_ready;
    assign dispatch_phys  = alloc_phys;

    assign commit_valid = ret_bus.valid;
    assign commit_arch  = ret_bus.arch;
    assign commit_phys  = ret_bus.phys;

    free_list #(.NUM_PHYS_REGS(NUM_PHYS_REGS)) u_free_list (
        .clk(clk), .rst(rst), .alloc_en(accept), .alloc_phys(alloc_phys),
        .alloc_ok(alloc_ok), .freed_valid(freed_valid), .freed_phys(freed_phys),
        .flush(flush), .mapped_mask(mapped_mask)
    );

    spec_rat #(.NUM_ARCH_REGS(NUM_ARCH_REGS)) u_spec_rat (
        .clk(clk), .rst(rst), .write_en(accept), .write_arch(dispatch_arch),
        .write_phys(alloc_phys), .read_arch(dispatch_arch), .read_phys(old_phys),
        .flush(flush), .retired_map(retired_map)
    );

    reorder_buffer #(.ROB_DEPTH(ROB_DEPTH)) u_reorder_buffer (
        .clk(clk), .rst(rst), .alloc_en(accept), .alloc_arch(dispatch_arch),
        .alloc_phys(alloc_phys), .alloc_old_phys(old_phys), .alloc_tag(dispatch_tag),
        .full(rob_full), .complete_valid(complete_valid), .complete_tag(complete_tag),
        .flush(flush), .ret(ret_bus.source)
    );

    retire_rat #(
        .NUM_ARCH_REGS(NUM_ARCH_REGS),
        .NUM_PHYS_REGS(NUM_PHYS_REGS)
    ) u_retire_rat (
        .clk(clk), .rst(rst), .ret(ret_bus.sink), .freed_valid(freed_valid),
        .freed_phys(freed_phys), .mapped_mask(mapped_mask), .retired_map(retired_map)
    );

endmodule

// File: source/rename_pkg.sv
package rename_pkg;

    // General architectural registers, flags sit at index NUM_ARCH_REGS
    parameter int NUM_ARCH_REGS = 8;

    // Physical register file size
    parameter int NUM_PHYS_REGS = 32;

    // Reorder buffer entries, must be a power of two
    parameter int ROB_DEPTH = 8;

    // Widths follow the defaults above
    parameter int ARCH_IDX_W = 4;
    parameter int PHYS_IDX_W = 5;
    parameter int ROB_TAG_W  = 3;

    // Architectural index
    // 0..7 are general registers, 8 is the flag register
    typedef logic [ARCH_IDX_W-1:0] arch_idx_t;

    // Physical register index
    typedef logic [PHYS_IDX_W-1:0] phys_idx_t;

    // Reorder buffer entry index
    typedef logic [ROB_TAG_W-1:0] rob_tag_t;

endpackage

// File: source/reorder_buffer.sv
`timescale 1ns/1ps

module reorder_buffer #(
    parameter int ROB_DEPTH = rename_pkg::ROB_DEPTH
) (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  alloc_en,
    input  rename_pkg::arch_idx_t alloc_arch,
    input  rename_pkg::phys_idx_t alloc_phys,
    input  rename_pkg::phys_idx_t alloc_old_phys,
    output rename_pkg::rob_tag_t  alloc_tag,
    output logic                  full,
    input  logic                  complete_valid,
    input  rename_pkg::rob_tag_t  complete_tag,
    input  logic                  flush,
    retire_if.source              ret
);

    localparam int CNT_W = $clog2(ROB_DEPTH + 1);

    // Entry control bits
    logic [ROB_DEPTH-1:0] valid_q;
    logic [ROB_DEPTH-1:0] done_q;

    // Entry payload
    rename_pkg::arch_idx_t arch_q [ROB_DEPTH];
    rename_pkg::phys_idx_t phys_q [ROB_DEPTH];
    // Previous mapping, kept for debug visibility
    rename_pkg::phys_idx_t old_phys_q [ROB_DEPTH];

    rename_pkg::rob_tag_t head;
    rename_pkg::rob_tag_t tail;
    logic [CNT_W-1:0]     count;

    logic retire;

    assign full      = (count == CNT_W'(ROB_DEPTH));
    assign alloc_tag = tail;

    // Head retires as soon as it is done
    assign retire    = valid_q[head] && done_q[head] && !flush;

    assign ret.valid = retire;
    assign ret.arch  = arch_q[head];
    assign ret.phys  = phys_q[head];
    assign ret.tag   = head;
    assign ret.flush = flush;

    always_ff @(posedge clk) begin
        if (rst || flush) begin
            valid_q <= '0;
            done_q  <= '0;
            head    <= '0;
            tail    <= '0;
            count   <= '0;
        end else begin
            if (alloc_en) begin
                valid_q[tail] <= 1'b1;
                done_q[tail]  <= 1'b0;
                tail          <= tail + 1'b1;
            end
            // Completions for dead entries are dropped
            if (complete_valid && valid_q[complete_tag]) begin
                done_q[complete_tag] <= 1'b1;
            end
            if (retire) begin
                valid_q[head] <= 1'b0;
                head          <= head + 1'b1;
            end
            case ({alloc_en, retire})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (alloc_en) begin
            arch_q[tail]     <= alloc_arch;
            phys_q[tail]     <= alloc_phys;
            old_phys_q[tail] <= alloc_old_phys;
        end
    end

endmodule

// File: source/retire_if.sv
`timescale 1ns/1ps

interface retire_if;

    // One retirement per cycle from the reorder buffer head
    logic                  valid;
    rename_pkg::arch_idx_t arch;
    rename_pkg::phys_idx_t phys;
    rename_pkg::rob_tag_t  tag;

    // Forwarded flush, never high together with valid
    logic                  flush;

    modport source (
        output valid, arch, phys, tag, flush
    );

    modport sink (
        input valid, arch, phys, tag, flush
    );

endinterface

// File: source/retire_rat.sv
`timescale 1ns/1ps

module retire_rat #(
    parameter int NUM_ARCH_REGS = rename_pkg::NUM_ARCH_REGS,
    parameter int NUM_PHYS_REGS = rename_pkg::NUM_PHYS_REGS
) (
    input  logic                     clk,
    input  logic                     rst,
    retire_if.sink                   ret,
    output logic                     freed_valid,
    output rename_pkg::phys_idx_t    freed_phys,
    output logic [NUM_PHYS_REGS-1:0] mapped_mask,
    output rename_pkg::phys_idx_t    retired_map [NUM_ARCH_REGS:0]
);

    // Committed map, flags at the top index
    rename_pkg::phys_idx_t map_q [NUM_ARCH_REGS:0];

    rename_pkg::phys_idx_t old_phys;
    logic                  commit;

    assign commit   = ret.valid && !ret.flush;
    assign old_phys = map_q[ret.arch];

    always_comb begin
        mapped_mask = '0;
        for (int i = 0; i <= NUM_ARCH_REGS; i++) begin
            mapped_mask[map_q[i]] = 1'b1;
            retired_map[i]        = map_q[i];
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i <= NUM_ARCH_REGS; i++) begin
                map_q[i] <= rename_pkg::phys_idx_t'(i);
            end
            freed_valid <= 1'b0;
        end else begin
            // Pulse lasts one cycle after the commit edge
            freed_valid <= commit && (old_phys != ret.phys);
            if (commit) begin
                map_q[ret.arch] <= ret.phys;
            end
        end
    end

    // Superseded register goes back to the free list
    always_ff @(posedge clk) begin
        if (commit) begin
            freed_phys <= old_phys;
        end
    end

endmodule

// File: source/spec_rat.sv
`timescale 1ns/1ps

module spec_rat #(
    parameter int NUM_ARCH_REGS = rename_pkg::NUM_ARCH_REGS
) (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  write_en,
    input  rename_pkg::arch_idx_t write_arch,
    input  rename_pkg::phys_idx_t write_phys,
    input  rename_pkg::arch_idx_t read_arch,
    output rename_pkg::phys_idx_t read_phys,
    input  logic                  flush,
    input  rename_pkg::phys_idx_t retired_map [NUM_ARCH_REGS:0]
);

    // Speculative map, flag register lives in the top entry
    rename_pkg::phys_idx_t map_q [NUM_ARCH_REGS:0];

    // Current mapping of the dispatching destination
    assign read_phys = map_q[read_arch];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i <= NUM_ARCH_REGS; i++) begin
                map_q[i] <= rename_pkg::phys_idx_t'(i);
            end
        end else if (flush) begin
            // Drop all speculative renames
            for (int i = 0; i <= NUM_ARCH_REGS; i++) begin
                map_q[i] <= retired_map[i];
            end
        end else if (write_en) begin
            map_q[write_arch] <= write_phys;
        end
    end

endmodule

// File: testbench/rename_core_asserts.sv
`timescale 1ns/1ps

module rename_core_asserts #(
    parameter int ROB_DEPTH = rename_pkg::ROB_DEPTH
) (
    input logic clk,
    input logic rst,
    input logic flush,
    input logic dispatch_valid,
    input logic dispatch_ready,
    input logic commit_valid,
    input logic freed_valid
);

    int fail_count = 0;

    // Micro-ops in flight, counted from the handshakes alone
    int live = 0;

    always @(posedge clk) begin
        if (rst || flush) begin
            live <= 0;
        end else begin
            live <= live + int'(dispatch_valid && dispatch_ready) - int'(commit_valid);
        end
    end

    // Flushed entries never reach commit
    no_commit_on_flush: assert property (@(posedge clk) disable iff (rst)
        flush |-> !commit_valid ##1 !commit_valid)
        else begin
            $error("commit_valid high during or right after a flush");
            fail_count++;
        end

    // Each freed cycle belongs to the commit one edge earlier
    freed_after_commit: assert property (@(posedge clk) disable iff (rst)
        freed_valid |-> $past(commit_valid))
        else begin
            $error("freed_valid high without a commit on the previous edge");
            fail_count++;
        end

    full_blocks_dispatch: assert property (@(posedge clk) disable iff (rst)
        (live == ROB_DEPTH) |-> !dispatch_ready)
        else begin
            $error("dispatch_ready high with a full reorder buffer");
            fail_count++;
        end

endmodule

bind rename_core rename_core_asserts #(.ROB_DEPTH(ROB_DEPTH)) u_asserts (
    .clk(clk),
    .rst(rst),
    .flush(flush),
    .dispatch_valid(dispatch_valid),
    .dispatch_ready(dispatch_ready),
    .commit_valid(commit_valid),
    .freed_valid(freed_valid)
);

// File: testbench/rename_core_tb.sv
`timescale 1ns/1ps

module rename_core_tb;

    localparam int NA = rename_pkg::NUM_ARCH_REGS;
    localparam int NP = rename_pkg::NUM_PHYS_REGS;
    localparam int RD = rename_pkg::ROB_DEPTH;
    // Planned cycles of the five tests, the run stops at twice this
    localparam int PLAN_CYCLES = 10 + 50 + 30 + 25 + 25;

    logic                  clk = 1'b0;
    logic                  rst = 1'b1;
    logic                  dispatch_valid = 1'b0;
    rename_pkg::arch_idx_t dispatch_arch = '0;
    logic                  dispatch_ready;
    rename_pkg::phys_idx_t dispatch_phys;
    rename_pkg::rob_tag_t  dispatch_tag;
    logic                  complete_valid = 1'b0;
    rename_pkg::rob_tag_t  complete_tag = '0;
    logic                  commit_valid;
    rename_pkg::arch_idx_t commit_arch;
    rename_pkg::phys_idx_t commit_phys;
    logic                  freed_valid;
    rename_pkg::phys_idx_t freed_phys;
    logic                  flush = 1'b0;

    // Reference model state
    logic [NP-1:0]         m_free;
    rename_pkg::phys_idx_t m_spec [NA:0];
    rename_pkg::phys_idx_t m_ret [NA:0];
    rename_pkg::arch_idx_t m_arch [RD];
    rename_pkg::phys_idx_t m_phys [RD];
    logic [RD-1:0]         m_done;
    rename_pkg::rob_tag_t  m_tail;
    rename_pkg::rob_tag_t  order_q [$];
    logic                  m_freed_v;
    rename_pkg::phys_idx_t m_freed_p;
    logic                  last_accept;
    logic [31:0]           lfsr_state = 32'h3d12;
    int                    errors = 0;
    int                    test_errors = 0;
    int                    cycles = 0;

    rename_core u_rename_core (.*);

    always #50 clk = ~clk;

    function automatic rename_pkg::phys_idx_t lowest_free(input logic [NP-1:0] fmap);
        for (int i = 0; i < NP; i++) begin
            if (fmap[i]) return rename_pkg::phys_idx_t'(i);
        end
        return '0;
    endfunction

    // Taps 32, 22, 2, 1
    task automatic take_bits(input int n, output int value);
        value = 0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = {lfsr_state[30:0],
                lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0]};
            value = (value << 1) | lfsr_state[0];
        end
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        assert (got === exp) else begin
            $display("ERR t=%0t %s got %0d expected %0d", $time, name, got, exp);
            errors++;
            test_errors++;
        end
    endtask

    task automatic note_failure(input string msg);
        $display("Failure at t=%0t: %s", $time, msg);
        errors++;
        test_errors++;
    endtask

    task automatic reset_model();
        for (int i = 0; i < NP; i++) m_free[i] = (i > NA);
        for (int i = 0; i <= NA; i++) begin
            m_spec[i] = rename_pkg::phys_idx_t'(i);
            m_ret[i]  = rename_pkg::phys_idx_t'(i);
        end
        order_q.delete();
        m_done      = '0;
        m_tail      = '0;
        m_freed_v   = 1'b0;
        last_accept = 1'b0;
    endtask

    task automatic compare_and_update();
        logic                  exp_ready;
        logic                  exp_commit;
        logic                  accept;
        rename_pkg::phys_idx_t new_phys;
        rename_pkg::rob_tag_t  hd;
        exp_ready  = (order_q.size() < RD) && (|m_free) && !flush;
        exp_commit = (order_q.size() > 0) && m_done[order_q[0]] && !flush;
        accept     = dispatch_valid && exp_ready;
        new_phys   = lowest_free(m_free);
        check_value("dispatch_ready", dispatch_ready, exp_ready);
        if (accept) begin
            check_value("dispatch_phys", dispatch_phys, new_phys);
            check_value("dispatch_tag", dispatch_tag, m_tail);
            check_value("old_phys", u_rename_core.old_phys, m_spec[dispatch_arch]);
        end
        check_value("commit_valid", commit_valid, exp_commit);
        if (exp_commit) begin
            check_value("commit_arch", commit_arch, m_arch[order_q[0]]);
            check_value("commit_phys", commit_phys, m_phys[order_q[0]]);
        end
        check_value("freed_valid", freed_valid, m_freed_v);
        if (m_freed_v) check_value("freed_phys", freed_phys, m_freed_p);
        if (flush) begin
            // Everything the retired table does not hold becomes free
            m_free = '1;
            for (int i = 0; i <= NA; i++) begin
                m_spec[i]        = m_ret[i];
                m_free[m_ret[i]] = 1'b0;
            end
            order_q.delete();
            m_tail    = '0;
            m_freed_v = 1'b0;
            accept    = 1'b0;
        end else begin
            if (m_freed_v) m_free[m_freed_p] = 1'b1;
            if (accept) m_free[new_phys] = 1'b0;
            foreach (order_q[i]) begin
                if (complete_valid && order_q[i] == complete_tag) m_done[complete_tag] = 1'b1;
            end
            m_freed_v = 1'b0;
            if (exp_commit) begin
                hd                = order_q.pop_front();
                m_freed_v         = (m_ret[m_arch[hd]] != m_phys[hd]);
                m_freed_p         = m_ret[m_arch[hd]];
                m_ret[m_arch[hd]] = m_phys[hd];
            end
            if (accept) begin
                m_arch[m_tail]        = dispatch_arch;
                m_phys[m_tail]        = new_phys;
                m_done[m_tail]        = 1'b0;
                m_spec[dispatch_arch] = new_phys;
                order_q.push_back(m_tail);
                m_tail++;
            end
        end
        last_accept = accept;
    endtask

    always @(posedge clk) begin
        if (rst) reset_model();
        else compare_and_update();
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles > 2 * PLAN_CYCLES) begin
            $display("Timeout: the run did not finish within %0d cycles", cycles);
            $display("TESTS FAILED");
            $finish;
        end
    end

    // Picks a live entry that has not completed yet
    task automatic drive_completion();
        rename_pkg::rob_tag_t cand [$];
        int                   pick;
        foreach (order_q[i]) begin
            if (!m_done[order_q[i]]) cand.push_back(order_q[i]);
        end
        complete_valid = 1'b0;
        if (cand.size() > 0) begin
            take_bits(3, pick);
            complete_valid = 1'b1;
            complete_tag   = cand[pick % cand.size()];
        end
    endtask

    task automatic random_arch(output int arch);
        int flag_bits;
        take_bits(2, flag_bits);
        if (flag_bits == 3) arch = NA;
        else take_bits(3, arch);
    endtask

    task automatic dispatch_one(input int arch);
        dispatch_valid = 1'b1;
        dispatch_arch  = rename_pkg::arch_idx_t'(arch);
        @(negedge clk);
        while (!last_accept) @(negedge clk);
        dispatch_valid = 1'b0;
    endtask

    task automatic drain();
        while (order_q.size() > 0) begin
            drive_completion();
            @(negedge clk);
        end
        complete_valid = 1'b0;
    endtask

    task automatic finish_test(input string name);
        $display("Test %s finished with %0d errors", name, test_errors);
        test_errors = 0;
    endtask

    initial begin
        int bits;
        int arch;
        repeat (4) @(negedge clk);
        rst = 1'b0;

        // Allocation order from reset, flag register last
        for (int i = 0; i < 5; i++) dispatch_one(i);
        dispatch_one(NA);
        finish_test("reset allocation");

        // Random traffic, a held micro-op keeps its values until accepted
        repeat (40) begin
            if (!dispatch_valid || last_accept) begin
                take_bits(1, bits);
                random_arch(arch);
                dispatch_valid = bits[0];
                dispatch_arch  = rename_pkg::arch_idx_t'(arch);
            end
            drive_completion();
            @(negedge clk);
        end
        while (dispatch_valid && !last_accept) begin
            drive_completion();
            @(negedge clk);
        end
        dispatch_valid = 1'b0;
        finish_test("out-of-order completion");

        // Freed registers come back two edges after commit
        drain();
        repeat (2) @(negedge clk);
        for (int i = 0; i < 4; i++) dispatch_one(2 * i + 1);
        dispatch_one(NA);
        finish_test("free and reuse");

        drain();
        for (int i = 0; i < RD; i++) dispatch_one(i % (NA + 1));
        dispatch_valid = 1'b1;
        dispatch_arch  = 4'd5;
        repeat (3) begin
            @(negedge clk);
            assert (!last_accept && !dispatch_ready)
                else note_failure("micro-op accepted while the reorder buffer was full");
        end
        complete_valid = 1'b1;
        complete_tag   = order_q[0];
        @(negedge clk);
        complete_valid = 1'b0;
        while (!last_accept) @(negedge clk);
        dispatch_valid = 1'b0;
        finish_test("full reorder buffer");

        // Younger entry completes first, then the head commits before the flush
        complete_valid = 1'b1;
        complete_tag   = order_q[3];
        @(negedge clk);
        complete_tag   = order_q[0];
        @(negedge clk);
        complete_valid = 1'b0;
        @(negedge clk);
        flush = 1'b1;
        @(negedge clk);
        flush = 1'b0;
        for (int i = 0; i < 6; i++) begin
            random_arch(arch);
            dispatch_one(arch);
        end
        drain();
        finish_test("flush recovery");

        errors += u_rename_core.u_asserts.fail_count;
        $display("5 tests run, %0d errors", errors);
        if (errors == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule
